// File: Makefile
# Verilator build and run of the clock overlay testbench

VERILATOR ?= verilator
TOP       ?= tb_clock_overlay
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= ALL CHECKS PASSED

SOURCES := $(wildcard src/*.sv sim/*.sv include/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source, a header or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# the run fails unless the pass line shows up in the simulator output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: include/clock_overlay_defs.svh
/*
 * clock overlay constants
 *   glyph geometry of the character ROM
 *   placement of the time string in the framebuffer
 *   pixel colours and the default second divider
 */

`ifndef CLOCK_OVERLAY_DEFS_SVH
`define CLOCK_OVERLAY_DEFS_SVH

// ==========================================================================
// glyph geometry
// ==========================================================================
`define CHAR_COUNT            8
`define GLYPH_LINES           24
`define GLYPH_WIDTH           13
// ROM glyph code of ':'
`define COLON_GLYPH           10

// ==========================================================================
// screen placement and colours
// ==========================================================================
`define FB_LINE_PITCH         256
// top-left pixel of "HH:MM:SS", relative to the framebuffer base
`define CLOCK_ORIGIN          59544
`define PIXEL_ON              24'hffffff
`define PIXEL_OFF             24'h000000

// system clock cycles per second
`define TICKS_PER_SEC_DEFAULT 1000000

`endif

// File: sim/tb_clock_overlay.sv
/*
 * clock overlay testbench
 *   clock, reset and stimulus aligned to the second tick
 *   character ROM and framebuffer models
 *   reference pixel and time increment, per-write compare
 */

`timescale 1ns/1ps
`include "clock_overlay_defs.svh"

module tb_clock_overlay;

	import clock_overlay_pkg::*;

	localparam int TICKS     = 4000;
	localparam int ROM_WORDS = (`COLON_GLYPH + 1) * `GLYPH_LINES;
	localparam int STR_WIDTH = `CHAR_COUNT * `GLYPH_WIDTH;
	localparam int WRITES    = STR_WIDTH * `GLYPH_LINES;

	logic        clk;
	logic        reset;
	logic        i_load;
	hour_t       i_init_hours;
	minsec_t     i_init_minutes;
	minsec_t     i_init_seconds;
	fb_addr_t    i_fb_base;
	glyph_line_t i_cr_q;
	glyph_addr_t o_cr_a;
	fb_addr_t    o_im_a;
	pixel_t      o_im_d;
	logic        o_im_wen;
	logic        o_drawing;

	glyph_line_t rom_table [0:ROM_WORDS-1];
	glyph_addr_t rom_addr;
	pixel_t      fb_mem [fb_addr_t];
	logic [31:0] rng_state;
	int          cycle;
	int          write_count;
	int          checks;
	int          errors;
	hour_t       exp_h;
	minsec_t     exp_m;
	minsec_t     exp_s;

	clock_overlay_top #(.TICKS_PER_SEC(TICKS)) u_dut (
		.clk(clk), .reset(reset), .i_load(i_load),
		.i_init_hours(i_init_hours), .i_init_minutes(i_init_minutes),
		.i_init_seconds(i_init_seconds), .i_fb_base(i_fb_base), .i_cr_q(i_cr_q),
		.o_cr_a(o_cr_a), .o_im_a(o_im_a), .o_im_d(o_im_d),
		.o_im_wen(o_im_wen), .o_drawing(o_drawing)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// edges since reset release, in step with the tick divider
	always @(posedge clk or posedge reset) begin
		if (reset) begin
			cycle <= 0;
		end else begin
			cycle <= cycle + 1;
		end
	end

	// ==========================================================================
	// reference model
	// ==========================================================================
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [16:0] next_time(input hour_t h, input minsec_t m,
		input minsec_t s);
		if (s != 6'd59) begin
			s = s + 6'd1;
		end else begin
			s = 6'd0;
			if (m != 6'd59) begin
				m = m + 6'd1;
			end else begin
				m = 6'd0;
				h = (h == 5'd23) ? 5'd0 : h + 5'd1;
			end
		end
		return {h, m, s};
	endfunction

	function automatic bit in_region(input fb_addr_t addr, input fb_addr_t base);
		fb_addr_t off;
		off = addr - base - fb_addr_t'(`CLOCK_ORIGIN);
		return (int'(off) / `FB_LINE_PITCH < `GLYPH_LINES) &&
			(int'(off) % `FB_LINE_PITCH < STR_WIDTH);
	endfunction

	function automatic pixel_t expected_pixel(input hour_t h, input minsec_t m,
		input minsec_t s, input fb_addr_t base, input fb_addr_t addr);
		fb_addr_t    off;
		int          row;
		int          col;
		pixel_idx_t  x;
		bcd_t        code;
		glyph_line_t word;
		off = addr - base - fb_addr_t'(`CLOCK_ORIGIN);
		row = int'(off) / `FB_LINE_PITCH;
		col = int'(off) % `FB_LINE_PITCH;
		if (!in_region(addr, base)) begin
			return `PIXEL_OFF;
		end
		x = pixel_idx_t'(col % `GLYPH_WIDTH);
		case (col / `GLYPH_WIDTH)
			0:       code = bcd_t'(h / 5'd10);
			1:       code = bcd_t'(h % 5'd10);
			3:       code = bcd_t'(m / 6'd10);
			4:       code = bcd_t'(m % 6'd10);
			6:       code = bcd_t'(s / 6'd10);
			7:       code = bcd_t'(s % 6'd10);
			default: code = bcd_t'(`COLON_GLYPH);
		endcase
		word = rom_table[glyph_addr_t'(int'(code) * `GLYPH_LINES + row)];
		return word[4'd12 - x] ? `PIXEL_ON : `PIXEL_OFF;
	endfunction

	// ==========================================================================
	// compare tasks
	// ==========================================================================
	task automatic check_pixel(input fb_addr_t addr, input pixel_t got, input pixel_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0d ns: o_im_d at %h got %h expected %h",
				$time, addr, got, exp);
		end
	endtask

	task automatic check_addr_in_region(input fb_addr_t addr, input fb_addr_t base);
		checks++;
		if (!in_region(addr, base)) begin
			errors++;
			$display("FAILED at %0d ns: o_im_a got %h expected %h..%h", $time, addr,
				base + fb_addr_t'(`CLOCK_ORIGIN), base + fb_addr_t'(`CLOCK_ORIGIN) +
				fb_addr_t'((`GLYPH_LINES - 1) * `FB_LINE_PITCH + STR_WIDTH - 1));
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("FAILED at %0d ns: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0d ns: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	// ==========================================================================
	// ROM and framebuffer models
	// ==========================================================================
	always @(negedge clk) begin
		rom_addr = o_cr_a;
	end

	always @(posedge clk) begin
		#1;
		i_cr_q = rom_table[rom_addr];
	end

	// every write is recorded and compared as it happens
	always @(negedge clk) begin
		if (!reset && o_im_wen === 1'b0) begin
			write_count++;
			fb_mem[o_im_a] = o_im_d;
			check_addr_in_region(o_im_a, i_fb_base);
			check_pixel(o_im_a, o_im_d, expected_pixel(exp_h, exp_m, exp_s, i_fb_base, o_im_a));
		end
	end

	// ==========================================================================
	// stimulus helpers
	// ==========================================================================
	task automatic abort_wait(input string what);
		$display("timeout while waiting for %s", what);
		$display("CHECKS FAILED");
		$finish;
	endtask

	task automatic wait_drawing(input logic level, input int limit, input string what);
		int n;
		n = 0;
		while (o_drawing !== level) begin
			if (n == limit) begin
				abort_wait(what);
			end else begin
				@(posedge clk);
				#1;
				n++;
			end
		end
	endtask

	// cycle where the divider pulses, a load here replaces the tick
	task automatic wait_tick_slot();
		int n;
		n = 0;
		@(posedge clk);
		#1;
		while (cycle % TICKS != 0) begin
			if (n == 2 * TICKS) begin
				abort_wait("a second tick");
			end else begin
				@(posedge clk);
				#1;
				n++;
			end
		end
	endtask

	task automatic load_at_slot(input hour_t h, input minsec_t m, input minsec_t s);
		wait_tick_slot();
		i_load         = 1'b1;
		i_init_hours   = h;
		i_init_minutes = m;
		i_init_seconds = s;
		@(posedge clk);
		#1;
		i_load = 1'b0;
	endtask

	task automatic expect_redraw(input hour_t h, input minsec_t m, input minsec_t s);
		exp_h       = h;
		exp_m       = m;
		exp_s       = s;
		write_count = 0;
		fb_mem.delete();
		wait_drawing(1'b1, 10, "o_drawing to rise");
		wait_drawing(1'b0, WRITES + 500, "o_drawing to fall");
		check_count("write count", write_count, WRITES);
		check_count("distinct addresses", fb_mem.num(), WRITES);
	endtask

	task automatic end_test(input int num, input string what, input int mark);
		$display("test %0d %s: %0d errors", num, what, errors - mark);
	endtask

	initial begin
		int      mark;
		hour_t   rh;
		minsec_t rm;
		minsec_t rs;
		reset          = 1'b1;
		i_load         = 1'b0;
		i_init_hours   = '0;
		i_init_minutes = '0;
		i_init_seconds = '0;
		i_fb_base      = '0;
		i_cr_q         = '0;
		checks         = 0;
		errors         = 0;
		exp_h          = '0;
		exp_m          = '0;
		exp_s          = '0;
		rng_state      = 32'h7deb3043;
		for (int i = 0; i < ROM_WORDS; i++) begin
			rng_state    = lcg_next(rng_state);
			rom_table[i] = rng_state[30:18];
		end
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;

		mark = errors;
		repeat (100) begin
			@(negedge clk);
			check_level("o_im_wen", o_im_wen, 1'b1);
			check_level("o_drawing", o_drawing, 1'b0);
		end
		end_test(1, "quiet after reset", mark);

		mark = errors;
		load_at_slot(5'd12, 6'd34, 6'd56);
		expect_redraw(5'd12, 6'd34, 6'd56);
		end_test(2, "load 12:34:56", mark);

		mark = errors;
		load_at_slot(5'd23, 6'd59, 6'd58);
		expect_redraw(5'd23, 6'd59, 6'd58);
		wait_tick_slot();
		expect_redraw(5'd23, 6'd59, 6'd59);
		wait_tick_slot();
		expect_redraw(5'd0, 6'd0, 6'd0);
		end_test(3, "midnight rollover", mark);

		// framebuffer moves while the scanner is idle
		mark = errors;
		i_fb_base = 20'h8a000;
		load_at_slot(5'd7, 6'd8, 6'd9);
		expect_redraw(5'd7, 6'd8, 6'd9);
		end_test(4, "new framebuffer base", mark);

		mark      = errors;
		rng_state = lcg_next(rng_state);
		rh        = hour_t'(rng_state[31:16] % 16'd24);
		rm        = minsec_t'(rng_state[15:0] % 16'd60);
		rng_state = lcg_next(rng_state);
		rs        = minsec_t'(rng_state[31:16] % 16'd60);
		load_at_slot(rh, rm, rs);
		expect_redraw(rh, rm, rs);
		{rh, rm, rs} = next_time(rh, rm, rs);
		wait_tick_slot();
		expect_redraw(rh, rm, rs);
		end_test(5, "random load and tick", mark);

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// File: src/clock_overlay_pkg.sv
/*
 * clock overlay types
 *   framebuffer, character ROM and time field widths
 *   scan position indices
 *   glyph scanner FSM states
 */

package clock_overlay_pkg;

	typedef logic [23:0] pixel_t;
	typedef logic [19:0] fb_addr_t;
	typedef logic [12:0] glyph_line_t;
	typedef logic [8:0]  glyph_addr_t;

	// one decimal digit, or a glyph code up to the colon
	typedef logic [3:0]  bcd_t;
	typedef logic [4:0]  hour_t;
	typedef logic [5:0]  minsec_t;

	// position inside one redraw
	typedef logic [2:0]  char_idx_t;
	typedef logic [4:0]  line_idx_t;
	typedef logic [3:0]  pixel_idx_t;

	typedef enum logic [1:0] {
		SCAN_IDLE,
		SCAN_FETCH,
		SCAN_WAIT,
		SCAN_WRITE
	} scan_state_t;

endpackage

// File: src/clock_overlay_top.sv
/*
 * clock overlay top level
 *   second tick, time keeper, glyph scanner, glyph writer
 *   character ROM read port and framebuffer write port
 */

`timescale 1ns/1ps
`include "clock_overlay_defs.svh"

module clock_overlay_top #(
	parameter int TICKS_PER_SEC = `TICKS_PER_SEC_DEFAULT
) (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           i_load,
	input  clock_overlay_pkg::hour_t       i_init_hours,
	input  clock_overlay_pkg::minsec_t     i_init_minutes,
	input  clock_overlay_pkg::minsec_t     i_init_seconds,
	input  clock_overlay_pkg::fb_addr_t    i_fb_base,
	input  clock_overlay_pkg::glyph_line_t i_cr_q,
	output clock_overlay_pkg::glyph_addr_t o_cr_a,
	output clock_overlay_pkg::fb_addr_t    o_im_a,
	output clock_overlay_pkg::pixel_t      o_im_d,
	output logic                           o_im_wen,
	output logic                           o_drawing
);

	import clock_overlay_pkg::*;

	logic       tick;
	logic       update;
	bcd_t       hour_tens, hour_ones, min_tens, min_ones, sec_tens, sec_ones;
	char_idx_t  char_idx;
	line_idx_t  line_idx;
	pixel_idx_t pixel_x;
	logic       fetch, write, active;

	second_tick_gen #(.TICKS_PER_SEC(TICKS_PER_SEC)) u_tick (
		.clk(clk), .reset(reset), .o_tick(tick)
	);

	time_keeper u_time (
		.clk(clk), .reset(reset), .i_tick(tick), .i_load(i_load),
		.i_init_hours(i_init_hours), .i_init_minutes(i_init_minutes),
		.i_init_seconds(i_init_seconds), .o_update(update),
		.o_hour_tens(hour_tens), .o_hour_ones(hour_ones),
		.o_min_tens(min_tens), .o_min_ones(min_ones),
		.o_sec_tens(sec_tens), .o_sec_ones(sec_ones)
	);

	// load -> update -> fetch -> wait -> registered pixel write
	glyph_scanner u_scan (
		.clk(clk), .reset(reset), .i_update(update),
		.o_char_idx(char_idx), .o_line_idx(line_idx), .o_pixel_x(pixel_x),
		.o_fetch(fetch), .o_write(write), .o_active(active)
	);

	glyph_writer u_writer (
		.clk(clk), .reset(reset), .i_fb_base(i_fb_base), .i_cr_q(i_cr_q),
		.i_hour_tens(hour_tens), .i_hour_ones(hour_ones),
		.i_min_tens(min_tens), .i_min_ones(min_ones),
		.i_sec_tens(sec_tens), .i_sec_ones(sec_ones),
		.i_char_idx(char_idx), .i_line_idx(line_idx), .i_pixel_x(pixel_x),
		.i_fetch(fetch), .i_write(write), .i_active(active),
		.o_cr_a(o_cr_a), .o_im_a(o_im_a), .o_im_d(o_im_d),
		.o_im_wen(o_im_wen), .o_drawing(o_drawing)
	);

endmodule

// File: src/glyph_scanner.sv
/*
 * glyph scanner
 *   FSM pacing one redraw of the eight-character string
 *   per glyph line: fetch, wait for the ROM, 13 pixel writes
 *   nested pixel / line / character counters
 */

`timescale 1ns/1ps
`include "clock_overlay_defs.svh"

module glyph_scanner (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          i_update,
	output clock_overlay_pkg::char_idx_t  o_char_idx,
	output clock_overlay_pkg::line_idx_t  o_line_idx,
	output clock_overlay_pkg::pixel_idx_t o_pixel_x,
	output logic                          o_fetch,
	output logic                          o_write,
	output logic                          o_active
);

	import clock_overlay_pkg::*;

	localparam char_idx_t  LAST_CHAR  = char_idx_t'(`CHAR_COUNT - 1);
	localparam line_idx_t  LAST_LINE  = line_idx_t'(`GLYPH_LINES - 1);
	localparam pixel_idx_t LAST_PIXEL = pixel_idx_t'(`GLYPH_WIDTH - 1);

	scan_state_t state;

	// ==========================================================================
	// state and counters
	// ==========================================================================
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state      <= SCAN_IDLE;
			o_char_idx <= '0;
			o_line_idx <= '0;
			o_pixel_x  <= '0;
		end else begin
			case (state)
				SCAN_IDLE: begin
					if (i_update) begin
						state      <= SCAN_FETCH;
						o_char_idx <= '0;
						o_line_idx <= '0;
						o_pixel_x  <= '0;
					end
				end
				SCAN_FETCH: begin
					state <= SCAN_WAIT;
				end
				SCAN_WAIT: begin
					state     <= SCAN_WRITE;
					o_pixel_x <= '0;
				end
				SCAN_WRITE: begin
					if (o_pixel_x == LAST_PIXEL) begin
						o_pixel_x <= '0;
						if (o_line_idx == LAST_LINE) begin
							o_line_idx <= '0;
							if (o_char_idx == LAST_CHAR) begin
								// whole string drawn
								state      <= SCAN_IDLE;
								o_char_idx <= '0;
							end else begin
								state      <= SCAN_FETCH;
								o_char_idx <= o_char_idx + 1'b1;
							end
						end else begin
							state      <= SCAN_FETCH;
							o_line_idx <= o_line_idx + 1'b1;
						end
					end else begin
						o_pixel_x <= o_pixel_x + 1'b1;
					end
				end
				default: begin
					state <= SCAN_IDLE;
				end
			endcase
		end
	end

	assign o_fetch  = (state == SCAN_FETCH);
	assign o_write  = (state == SCAN_WRITE);
	assign o_active = (state != SCAN_IDLE);

	// tick period must cover a full redraw
	a_update_when_idle: assert property (@(posedge clk) disable iff (reset)
		i_update |-> state == SCAN_IDLE);

endmodule

// File: src/glyph_writer.sv
/*
 * glyph writer
 *   digit / colon select per character position
 *   character ROM address at each line fetch
 *   framebuffer address, colour and write strobe per pixel
 */

`timescale 1ns/1ps
`include "clock_overlay_defs.svh"

module glyph_writer (
	input  logic                          clk,
	input  logic                          reset,
	input  clock_overlay_pkg::fb_addr_t   i_fb_base,
	input  clock_overlay_pkg::glyph_line_t i_cr_q,
	input  clock_overlay_pkg::bcd_t       i_hour_tens,
	input  clock_overlay_pkg::bcd_t       i_hour_ones,
	input  clock_overlay_pkg::bcd_t       i_min_tens,
	input  clock_overlay_pkg::bcd_t       i_min_ones,
	input  clock_overlay_pkg::bcd_t       i_sec_tens,
	input  clock_overlay_pkg::bcd_t       i_sec_ones,
	input  clock_overlay_pkg::char_idx_t  i_char_idx,
	input  clock_overlay_pkg::line_idx_t  i_line_idx,
	input  clock_overlay_pkg::pixel_idx_t i_pixel_x,
	input  logic                          i_fetch,
	input  logic                          i_write,
	input  logic                          i_active,
	output clock_overlay_pkg::glyph_addr_t o_cr_a,
	output clock_overlay_pkg::fb_addr_t   o_im_a,
	output clock_overlay_pkg::pixel_t     o_im_d,
	output logic                          o_im_wen,
	output logic                          o_drawing
);

	import clock_overlay_pkg::*;

	localparam bcd_t       COLON    = bcd_t'(`COLON_GLYPH);
	localparam pixel_idx_t MSB_BIT  = pixel_idx_t'(`GLYPH_WIDTH - 1);

	bcd_t        glyph_code;
	glyph_addr_t cr_addr;
	fb_addr_t    pixel_addr;
	pixel_idx_t  bit_sel;

	// "HH:MM:SS", position 0 on the left
	always_comb begin
		case (i_char_idx)
			3'd0:    glyph_code = i_hour_tens;
			3'd1:    glyph_code = i_hour_ones;
			3'd3:    glyph_code = i_min_tens;
			3'd4:    glyph_code = i_min_ones;
			3'd6:    glyph_code = i_sec_tens;
			3'd7:    glyph_code = i_sec_ones;
			default: glyph_code = COLON;
		endcase
	end

	// glyphs are stacked in the ROM, GLYPH_LINES words each
	assign cr_addr = glyph_addr_t'(glyph_code) * glyph_addr_t'(`GLYPH_LINES) +
		glyph_addr_t'(i_line_idx);

	assign pixel_addr = i_fb_base + fb_addr_t'(`CLOCK_ORIGIN) +
		fb_addr_t'(i_line_idx) * fb_addr_t'(`FB_LINE_PITCH) +
		fb_addr_t'(i_char_idx) * fb_addr_t'(`GLYPH_WIDTH) + fb_addr_t'(i_pixel_x);

	// leftmost pixel sits in the ROM word's msb
	assign bit_sel = MSB_BIT - i_pixel_x;

	// ==========================================================================
	// ROM address and pixel data
	// ==========================================================================
	always_ff @(posedge clk) begin
		if (i_fetch) begin
			o_cr_a <= cr_addr;
		end
		if (i_write) begin
			o_im_a <= pixel_addr;
			o_im_d <= i_cr_q[bit_sel] ? `PIXEL_ON : `PIXEL_OFF;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			o_im_wen  <= 1'b1;
			o_drawing <= 1'b0;
		end else begin
			o_im_wen  <= ~i_write;
			o_drawing <= i_active;
		end
	end

	// digits from the time keeper must stay within the ROM's glyph set
	a_glyph_code: assert property (@(posedge clk) disable iff (reset)
		i_fetch |-> glyph_code <= COLON);

endmodule

// File: src/second_tick_gen.sv
/*
 * second tick generator
 *   free-running counter over TICKS_PER_SEC system clocks
 *   one-cycle o_tick on each wrap
 */

`timescale 1ns/1ps
`include "clock_overlay_defs.svh"

module second_tick_gen #(
	parameter int TICKS_PER_SEC = `TICKS_PER_SEC_DEFAULT
) (
	input  logic clk,
	input  logic reset,
	output logic o_tick
);

	localparam int CNT_W = (TICKS_PER_SEC > 1) ? $clog2(TICKS_PER_SEC) : 1;
	localparam logic [CNT_W-1:0] LAST_COUNT = CNT_W'(TICKS_PER_SEC - 1);

	logic [CNT_W-1:0] count;

	// wrap at the terminal count
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			count  <= '0;
			o_tick <= 1'b0;
		end else begin
			if (count == LAST_COUNT) begin
				count <= '0;
			end else begin
				count <= count + 1'b1;
			end
			o_tick <= (count == LAST_COUNT);
		end
	end

endmodule

// File: src/time_keeper.sv
/*
 * time keeper
 *   binary hours, minutes and seconds with load and tick
 *   cascaded rollover, 23:59:59 -> 00:00:00
 *   BCD split of each field and a redraw strobe
 */

`timescale 1ns/1ps

module time_keeper (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       i_tick,
	input  logic                       i_load,
	input  clock_overlay_pkg::hour_t   i_init_hours,
	input  clock_overlay_pkg::minsec_t i_init_minutes,
	input  clock_overlay_pkg::minsec_t i_init_seconds,
	output logic                       o_update,
	output clock_overlay_pkg::bcd_t    o_hour_tens,
	output clock_overlay_pkg::bcd_t    o_hour_ones,
	output clock_overlay_pkg::bcd_t    o_min_tens,
	output clock_overlay_pkg::bcd_t    o_min_ones,
	output clock_overlay_pkg::bcd_t    o_sec_tens,
	output clock_overlay_pkg::bcd_t    o_sec_ones
);

	import clock_overlay_pkg::*;

	hour_t   hours;
	minsec_t minutes;
	minsec_t seconds;

	// tens and ones of a value below 60, packed as {tens, ones}
	function automatic logic [7:0] to_bcd(input minsec_t value);
		bcd_t    tens;
		minsec_t rest;
		if (value < 6'd10) begin
			tens = 4'd0;
		end else if (value < 6'd20) begin
			tens = 4'd1;
		end else if (value < 6'd30) begin
			tens = 4'd2;
		end else if (value < 6'd40) begin
			tens = 4'd3;
		end else if (value < 6'd50) begin
			tens = 4'd4;
		end else begin
			tens = 4'd5;
		end
		rest = value - minsec_t'(tens * 10);
		return {tens, bcd_t'(rest)};
	endfunction

	// ==========================================================================
	// time registers, load wins over tick
	// ==========================================================================
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			hours    <= '0;
			minutes  <= '0;
			seconds  <= '0;
			o_update <= 1'b0;
		end else begin
			if (i_load) begin
				hours   <= i_init_hours;
				minutes <= i_init_minutes;
				seconds <= i_init_seconds;
			end else if (i_tick) begin
				if (seconds == 6'd59) begin
					seconds <= '0;
					if (minutes == 6'd59) begin
						minutes <= '0;
						hours   <= (hours == 5'd23) ? '0 : hours + 1'b1;
					end else begin
						minutes <= minutes + 1'b1;
					end
				end else begin
					seconds <= seconds + 1'b1;
				end
			end
			// redraw once the new time is in place
			o_update <= i_load | i_tick;
		end
	end

	assign {o_hour_tens, o_hour_ones} = to_bcd(minsec_t'(hours));
	assign {o_min_tens, o_min_ones}   = to_bcd(minutes);
	assign {o_sec_tens, o_sec_ones}   = to_bcd(seconds);

	// host must only load a valid time of day
	a_load_in_range: assert property (@(posedge clk) disable iff (reset)
		i_load |-> (i_init_hours < 5'd24 && i_init_minutes < 6'd60 &&
			i_init_seconds < 6'd60));

endmodule

// File: verilog.f
+incdir+include
src/clock_overlay_pkg.sv
src/second_tick_gen.sv
src/time_keeper.sv
src/glyph_scanner.sv
src/glyph_writer.sv
src/clock_overlay_top.sv
sim/tb_clock_overlay.sv
